// File: hdl/line_buffer_ram.sv
// ##########################################################
// dual clock line RAM
// ##########################################################

`timescale 1ns/1ps

module line_buffer_ram #(
    parameter int data_w = 12,
    parameter int addr_w = 8
) (
    input  logic              clk_wr,
    input  logic              wr_en,
    input  logic [addr_w-1:0] wr_addr,
    input  logic [data_w-1:0] wr_data,
    input  logic              clk_rd,
    input  logic [addr_w-1:0] rd_addr,
    output logic [data_w-1:0] rd_data
);

    logic [data_w-1:0] mem [2**addr_w];         // one game line

    // game side port
    always_ff @(posedge clk_wr) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // vga side port, one cycle read latency
    always_ff @(posedge clk_rd) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hdl/line_writer.sv
// ##########################################################
// game line write control
// ##########################################################

`timescale 1ns/1ps

module line_writer (
    input  logic                             clk_rgb,
    input  logic                             rst,
    input  logic                             cen6,
    input  logic                             lhbl,
    output logic [scan_dbl_pkg::line_aw-1:0] wr_addr,
    output logic                             wr_en,
    output logic                             wr_bank
);

    logic last_lhbl;                            // lhbl one clk_rgb ago
    logic lhbl_fall;

    // a pixel is taken on every pixel strobe of the visible line
    assign wr_en     = lhbl & cen6;
    assign lhbl_fall = last_lhbl & ~lhbl;       // line just finished

    always_ff @(posedge clk_rgb or posedge rst) begin
        if (rst) begin
            last_lhbl <= 1'b0;
        end else begin
            last_lhbl <= lhbl;
        end
    end

    // pixel position within the line
    always_ff @(posedge clk_rgb or posedge rst) begin
        if (rst) begin
            wr_addr <= '0;
        end else if (!lhbl) begin
            wr_addr <= '0;                      // park at column 0 in hblank
        end else if (cen6) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    // ping-pong bank, the finished line goes over to the read side
    always_ff @(posedge clk_rgb or posedge rst) begin
        if (rst) begin
            wr_bank <= 1'b0;
        end else if (lhbl_fall) begin
            wr_bank <= ~wr_bank;
        end
    end

endmodule

// File: hdl/scan_dbl_pkg.sv
// ##########################################################
// scan doubler shared definitions
// ##########################################################

package scan_dbl_pkg;

    // line buffer depth, one game line
    localparam int unsigned line_aw = 8;            // 256 pixels

    // 31 kHz line timing in clk_vga cycles
    localparam int unsigned h_sync_len  = 96;       // hsync low
    localparam int unsigned h_front_len = 16;       // sync end to line start
    localparam int unsigned h_left_len  = 63;       // border before pixels
    localparam int unsigned h_right_len = 61;       // border after pixels
    localparam int unsigned h_back_len  = 48;       // line end to next sync

    // phases of one VGA line
    typedef enum logic [1:0] {
        st_sync,                                    // hsync pulse or pair wait
        st_front,
        st_line,                                    // borders and pixels
        st_back
    } line_state_t;

endpackage

// File: hdl/scan_doubler.sv
// ##########################################################
// 15 kHz to 31 kHz scan doubler
// ##########################################################

`timescale 1ns/1ps

module scan_doubler #(
    parameter int colorw = 4
) (
    input  logic              clk_rgb,
    input  logic              cen6,
    input  logic              clk_vga,
    input  logic              rst,
    input  logic [colorw-1:0] red,
    input  logic [colorw-1:0] green,
    input  logic [colorw-1:0] blue,
    input  logic              lhbl,
    input  logic              lvbl,
    input  logic              en_mixing,
    output logic [colorw:0]   vga_red,
    output logic [colorw:0]   vga_green,
    output logic [colorw:0]   vga_blue,
    output logic              vga_hsync,
    output logic              vga_vsync,
    output logic              vga_hb,
    output logic              vga_vb
);

    logic [scan_dbl_pkg::line_aw-1:0] wr_addr;
    logic                             wr_en;
    logic                             wr_bank;
    logic [scan_dbl_pkg::line_aw-1:0] rd_addr;
    logic                             rd_bank;
    logic                             pix_phase;
    logic                             blank;
    logic                             scanline;
    logic [3*colorw-1:0]              buf0_rgb;
    logic [3*colorw-1:0]              buf1_rgb;

    line_writer u_writer (
        .clk_rgb (clk_rgb),
        .rst     (rst),
        .cen6    (cen6),
        .lhbl    (lhbl),
        .wr_addr (wr_addr),
        .wr_en   (wr_en),
        .wr_bank (wr_bank)
    );

    line_buffer_ram #(
        .data_w (3*colorw),
        .addr_w (scan_dbl_pkg::line_aw)
    ) u_ram0 (
        .clk_wr  (clk_rgb),
        .wr_en   (wr_en & ~wr_bank),            // bank 0
        .wr_addr (wr_addr),
        .wr_data ({red, green, blue}),
        .clk_rd  (clk_vga),
        .rd_addr (rd_addr),
        .rd_data (buf0_rgb)
    );

    line_buffer_ram #(
        .data_w (3*colorw),
        .addr_w (scan_dbl_pkg::line_aw)
    ) u_ram1 (
        .clk_wr  (clk_rgb),
        .wr_en   (wr_en & wr_bank),             // bank 1
        .wr_addr (wr_addr),
        .wr_data ({red, green, blue}),
        .clk_rd  (clk_vga),
        .rd_addr (rd_addr),
        .rd_data (buf1_rgb)
    );

    vga_line_timer u_timer (
        .clk_vga   (clk_vga),
        .rst       (rst),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .wr_bank   (wr_bank),
        .rd_addr   (rd_addr),
        .rd_bank   (rd_bank),
        .pix_phase (pix_phase),
        .blank     (blank),
        .scanline  (scanline),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_hb    (vga_hb),
        .vga_vb    (vga_vb)
    );

    vga_color_mix #(
        .colorw (colorw)
    ) u_mix (
        .clk_vga   (clk_vga),
        .rst       (rst),
        .buf0_rgb  (buf0_rgb),
        .buf1_rgb  (buf1_rgb),
        .rd_bank   (rd_bank),
        .pix_phase (pix_phase),
        .blank     (blank),
        .scanline  (scanline),
        .en_mixing (en_mixing),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue)
    );

endmodule

// File: hdl/vga_color_mix.sv
// ##########################################################
// pixel expand, scanline blend and blanking
// ##########################################################

`timescale 1ns/1ps

module vga_color_mix #(
    parameter int colorw = 4
) (
    input  logic                  clk_vga,
    input  logic                  rst,
    input  logic [3*colorw-1:0]   buf0_rgb,
    input  logic [3*colorw-1:0]   buf1_rgb,
    input  logic                  rd_bank,
    input  logic                  pix_phase,
    input  logic                  blank,
    input  logic                  scanline,
    input  logic                  en_mixing,
    output logic [colorw:0]       vga_red,
    output logic [colorw:0]       vga_green,
    output logic [colorw:0]       vga_blue
);

    logic [colorw:0] mix_c [3];                 // 2 red, 1 green, 0 blue
    logic            blend;
    logic            blank_q;                   // blank one cycle back

    assign blend = scanline & en_mixing;

    for (genvar ch = 0; ch < 3; ch++) begin : g_chan
        logic [colorw-1:0] raw0;
        logic [colorw-1:0] raw1;
        logic [colorw:0]   ext0;
        logic [colorw:0]   ext1;
        logic [colorw+1:0] sum;

        assign raw0 = buf0_rgb[ch*colorw +: colorw];
        assign raw1 = buf1_rgb[ch*colorw +: colorw];

        // msb copied into the new lsb keeps full scale at full scale
        assign ext0 = {raw0, raw0[colorw-1]};
        assign ext1 = {raw1, raw1[colorw-1]};

        assign sum        = {1'b0, ext0} + {1'b0, ext1};
        assign mix_c[ch]  = blend ? sum[colorw+1:1] : (rd_bank ? ext1 : ext0);
    end

    always_ff @(posedge clk_vga or posedge rst) begin
        if (rst) begin
            blank_q   <= 1'b1;
            vga_red   <= '0;
            vga_green <= '0;
            vga_blue  <= '0;
        end else begin
            // hold off blanking while the last pixel still has its second copy
            blank_q <= blank & ~pix_phase;
            if (blank_q) begin
                vga_red   <= '0;
                vga_green <= '0;
                vga_blue  <= '0;
            end else begin
                vga_red   <= mix_c[2];
                vga_green <= mix_c[1];
                vga_blue  <= mix_c[0];
            end
        end
    end

endmodule

// File: hdl/vga_line_timer.sv
// ##########################################################
// 31 kHz line and frame timing
// ##########################################################

`timescale 1ns/1ps

module vga_line_timer (
    input  logic                             clk_vga,
    input  logic                             rst,
    input  logic                             lhbl,
    input  logic                             lvbl,
    input  logic                             wr_bank,
    output logic [scan_dbl_pkg::line_aw-1:0] rd_addr,
    output logic                             rd_bank,
    output logic                             pix_phase,
    output logic                             blank,
    output logic                             scanline,
    output logic                             vga_hsync,
    output logic                             vga_vsync,
    output logic                             vga_hb,
    output logic                             vga_vb
);

    localparam logic [6:0] sync_last  = 7'(scan_dbl_pkg::h_sync_len - 1);
    localparam logic [6:0] front_last = 7'(scan_dbl_pkg::h_front_len - 1);
    localparam logic [6:0] left_last  = 7'(scan_dbl_pkg::h_left_len - 1);
    localparam logic [6:0] right_last = 7'(scan_dbl_pkg::h_right_len - 1);
    localparam logic [6:0] back_last  = 7'(scan_dbl_pkg::h_back_len - 1);

    scan_dbl_pkg::line_state_t state;
    logic [6:0] cnt;                            // phase length down counter
    logic       sync_wait;                      // first line of a pair, wait for game
    logic       in_pix;                         // pixel window of st_line
    logic       in_right;                       // right border of st_line
    logic       lhbl_s1, lhbl_s2, lhbl_d;
    logic       lvbl_s1, lvbl_s2, lvbl_d;
    logic       wr_bank_s1, wr_bank_s2;
    logic       lhbl_fall, lvbl_fall;
    logic       hs_start;                       // hsync falling edge this cycle
    logic       vsync_req;
    logic       vs_second;                      // second line of vsync

    // game levels into clk_vga
    always_ff @(posedge clk_vga or posedge rst) begin
        if (rst) begin
            lhbl_s1    <= 1'b0;
            lhbl_s2    <= 1'b0;
            lhbl_d     <= 1'b0;
            lvbl_s1    <= 1'b0;
            lvbl_s2    <= 1'b0;
            lvbl_d     <= 1'b0;
            wr_bank_s1 <= 1'b0;
            wr_bank_s2 <= 1'b0;
        end else begin
            lhbl_s1    <= lhbl;
            lhbl_s2    <= lhbl_s1;
            lhbl_d     <= lhbl_s2;                  // edge detect only
            lvbl_s1    <= lvbl;
            lvbl_s2    <= lvbl_s1;
            lvbl_d     <= lvbl_s2;
            wr_bank_s1 <= wr_bank;
            wr_bank_s2 <= wr_bank_s1;
        end
    end

    assign lhbl_fall = lhbl_d & ~lhbl_s2;
    assign lvbl_fall = lvbl_d & ~lvbl_s2;

    // second line of a pair starts its sync right after st_back,
    // the first one only once the game has finished a line
    assign hs_start = (state == scan_dbl_pkg::st_sync && sync_wait && lhbl_fall) ||
                      (state == scan_dbl_pkg::st_back && cnt == 7'd0 && scanline);

    always_ff @(posedge clk_vga or posedge rst) begin
        if (rst) begin
            state     <= scan_dbl_pkg::st_sync;
            cnt       <= sync_last;
            sync_wait <= 1'b1;
            in_pix    <= 1'b0;
            in_right  <= 1'b0;
            rd_addr   <= '0;
            pix_phase <= 1'b0;
            rd_bank   <= 1'b0;
            blank     <= 1'b1;
            scanline  <= 1'b0;
            vga_hsync <= 1'b1;
            vga_hb    <= 1'b1;
        end else begin
            if (hs_start) begin
                vga_hsync <= 1'b0;
            end
            case (state)
                scan_dbl_pkg::st_sync: begin
                    if (sync_wait) begin
                        if (lhbl_fall) begin
                            sync_wait <= 1'b0;      // pair locked to game line
                        end
                    end else if (cnt == 7'd0) begin
                        state     <= scan_dbl_pkg::st_front;
                        cnt       <= front_last;
                        vga_hsync <= 1'b1;
                        if (!scanline) begin
                            rd_bank <= ~wr_bank_s2; // bank the game just closed
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                scan_dbl_pkg::st_front: begin
                    if (cnt == 7'd0) begin
                        state    <= scan_dbl_pkg::st_line;
                        cnt      <= left_last;
                        scanline <= ~scanline;
                        vga_hb   <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                scan_dbl_pkg::st_line: begin
                    if (in_right) begin
                        if (cnt == 7'd0) begin
                            state    <= scan_dbl_pkg::st_back;
                            cnt      <= back_last;
                            in_right <= 1'b0;
                            vga_hb   <= 1'b1;
                        end else begin
                            cnt <= cnt - 1'b1;
                        end
                    end else if (in_pix) begin
                        if (&{rd_addr, pix_phase}) begin
                            in_pix   <= 1'b0;
                            in_right <= 1'b1;
                            cnt      <= right_last;
                        end
                        // high from the second copy of the last pixel on
                        blank <= &rd_addr;
                        {rd_addr, pix_phase} <= {rd_addr, pix_phase} + 1'b1;
                    end else if (cnt == 7'd0) begin
                        in_pix <= 1'b1;
                        blank  <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                scan_dbl_pkg::st_back: begin
                    if (cnt == 7'd0) begin
                        state     <= scan_dbl_pkg::st_sync;
                        cnt       <= sync_last;
                        sync_wait <= ~scanline;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= scan_dbl_pkg::st_sync;
            endcase
        end
    end

    // vsync spans two VGA lines, hsync edge to hsync edge
    always_ff @(posedge clk_vga or posedge rst) begin
        if (rst) begin
            vsync_req <= 1'b0;
            vs_second <= 1'b0;
            vga_vsync <= 1'b1;
            vga_vb    <= 1'b1;
        end else begin
            vga_vb <= ~lvbl_s2;
            if (hs_start) begin
                if (!vga_vsync) begin
                    vs_second <= 1'b1;
                    if (vs_second) begin
                        vga_vsync <= 1'b1;
                    end
                end else if (vsync_req) begin
                    vga_vsync <= 1'b0;
                    vs_second <= 1'b0;
                    vsync_req <= 1'b0;
                end
            end
            if (lvbl_fall) begin
                vsync_req <= 1'b1;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the scan doubler testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f \
    --top-module scan_doubler_tb \
    --Mdir obj_dir \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: tb.f
hdl/scan_dbl_pkg.sv
hdl/line_buffer_ram.sv
hdl/line_writer.sv
hdl/vga_line_timer.sv
hdl/vga_color_mix.sv
hdl/scan_doubler.sv
verif/scan_doubler_tb.sv

// File: verif/scan_doubler_tb.sv
// ##########################################################
// scan doubler testbench
// ##########################################################

`timescale 1ns/1ps

module scan_doubler_tb;

    localparam int max_cycles = 80000;          // about three game frames

    logic clk_rgb = 1'b0;
    logic clk_vga = 1'b0;
    logic cen6, rst, lhbl, lvbl, en_mixing;
    logic [3:0] red, green, blue;
    logic [4:0] vga_red, vga_green, vga_blue;
    logic vga_hsync, vga_vsync, vga_hb, vga_vb;

    integer     seed = 32'hed2a_ebdc;
    int         errors = 0;
    int         cycles = 0;
    logic       gen_on = 1'b0;
    logic [1:0] div = 2'd0;
    int         hpos = 419;                     // first strobe wraps to column 0
    int         line_cnt = -1;
    int         done_line = -1;                 // last game line fully written
    int         nxt_pos, nxt_line;
    logic [11:0] pix;
    logic [11:0] game_pix [4][256];            // recent game lines
    logic [14:0] line_a[$], line_b[$], cap_q[$];

    scan_doubler #(.colorw(4)) i_dut (.*);

    always #2 clk_vga = ~clk_vga;
    always #2.1 clk_rgb = ~clk_rgb;

    always @(posedge clk_vga) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d clk_vga cycles, tests did not finish", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [3:0] nonzero4(logic [3:0] v);
        return (v == 4'd0) ? 4'h8 : v;
    endfunction

    function automatic logic [11:0] make_pixel();
        logic [31:0] r;
        r = $random(seed);
        return {nonzero4(r[3:0]), nonzero4(r[7:4]), nonzero4(r[11:8])};
    endfunction

    // each channel gets its msb appended
    function automatic logic [14:0] expand_pix(logic [11:0] p);
        return {p[11:8], p[11], p[7:4], p[7], p[3:0], p[3]};
    endfunction

    function automatic logic [14:0] blend_pix(logic [14:0] a, logic [14:0] b);
        logic [5:0] r, g, bl;
        r  = {1'b0, a[14:10]} + {1'b0, b[14:10]};
        g  = {1'b0, a[9:5]} + {1'b0, b[9:5]};
        bl = {1'b0, a[4:0]} + {1'b0, b[4:0]};
        return {r[5:1], g[5:1], bl[5:1]};
    endfunction

    // game video, 420 strobes per line, 256 visible, 8 of 12 lines active
    always @(posedge clk_rgb) begin
        if (gen_on) begin
            if (div == 2'd3) begin
                div      <= 2'd0;
                cen6     <= 1'b1;
                nxt_pos  = (hpos == 419) ? 0 : hpos + 1;
                nxt_line = (hpos == 419) ? line_cnt + 1 : line_cnt;
                hpos     <= nxt_pos;
                line_cnt <= nxt_line;
                lvbl     <= (nxt_line % 12) < 8;
                lhbl     <= nxt_pos < 256;
                if (nxt_pos < 256) begin
                    pix = make_pixel();
                    game_pix[nxt_line % 4][nxt_pos] = pix;
                    {red, green, blue} <= pix;
                end
                if (nxt_pos == 256) begin
                    done_line <= nxt_line;      // line handed to the vga side
                end
            end else begin
                div  <= div + 1'b1;
                cen6 <= 1'b0;
            end
        end
    end

    task automatic check_reset_state(input string when_s);
        assert (vga_hsync === 1'b1 && vga_vsync === 1'b1) else begin
            errors++;
            $display("Fail t=%0t vga_hsync/vga_vsync %s expected 1/1 got %b/%b",
                     $time, when_s, vga_hsync, vga_vsync);
        end
        assert (vga_hb === 1'b1 && vga_vb === 1'b1) else begin
            errors++;
            $display("Fail t=%0t vga_hb/vga_vb %s expected 1/1 got %b/%b",
                     $time, when_s, vga_hb, vga_vb);
        end
        assert ({vga_red, vga_green, vga_blue} === 15'd0) else begin
            errors++;
            $display("Fail t=%0t vga_rgb %s expected %h got %h",
                     $time, when_s, 15'd0, {vga_red, vga_green, vga_blue});
        end
    endtask

    task automatic wait_lhbl_fall();
        logic prev;
        prev = lhbl;
        @(negedge clk_vga);
        while (!(prev && !lhbl)) begin
            prev = lhbl;
            @(negedge clk_vga);
        end
    endtask

    // nonzero colour words of the next vga line
    task automatic capture_line();
        logic prev;
        cap_q = {};
        prev  = vga_hsync;
        @(negedge clk_vga);
        while (!(prev && !vga_hsync)) begin
            prev = vga_hsync;
            @(negedge clk_vga);
        end
        while (vga_hb) @(negedge clk_vga);
        while (!vga_hb) begin
            if ({vga_red, vga_green, vga_blue} != 15'd0)
                cap_q.push_back({vga_red, vga_green, vga_blue});
            @(negedge clk_vga);
        end
    endtask

    task automatic check_words(input logic [14:0] q[$], input int src, input bit mixed);
        logic [14:0] exp_w;
        assert (q.size() == 512) else begin
            errors++;
            $display("Fail t=%0t line word count expected 512 got %0d", $time, q.size());
        end
        for (int i = 0; i < q.size() && i < 512; i++) begin
            exp_w = expand_pix(game_pix[src % 4][i / 2]);
            if (mixed)
                exp_w = blend_pix(exp_w, expand_pix(game_pix[(src + 3) % 4][i / 2]));
            assert (q[i] == exp_w) else begin
                errors++;
                $display("Fail t=%0t vga_rgb word %0d expected %h got %h",
                         $time, i, exp_w, q[i]);
            end
        end
    endtask

    task automatic check_line_pairing();
        int   falls = 0;
        int   low_len = 0;
        bit   done = 0;
        logic prev_lhbl, prev_hs;
        wait_lhbl_fall();
        prev_lhbl = lhbl;
        prev_hs   = vga_hsync;
        while (!done) begin
            @(negedge clk_vga);
            if (prev_lhbl && !lhbl) done = 1;
            if (!vga_hsync) low_len++;
            if (prev_hs && !vga_hsync) falls++;
            if (!prev_hs && vga_hsync) begin
                assert (low_len == 96) else begin
                    errors++;
                    $display("Fail t=%0t vga_hsync low cycles expected 96 got %0d",
                             $time, low_len);
                end
                low_len = 0;
            end
            prev_lhbl = lhbl;
            prev_hs   = vga_hsync;
        end
        assert (falls == 2) else begin
            errors++;
            $display("Fail t=%0t vga_hsync falls per game line expected 2 got %0d",
                     $time, falls);
        end
    endtask

    task automatic check_pair(input bit mixed);
        int src;
        @(posedge clk_vga) en_mixing <= mixed;
        wait_lhbl_fall();
        src = done_line;
        capture_line();
        line_a = cap_q;
        capture_line();
        line_b = cap_q;
        check_words(line_a, src, mixed);        // first line blends when mixing
        check_words(line_b, src, 1'b0);
        if (!mixed) begin
            assert (line_a == line_b) else begin
                errors++;
                $display("the two vga lines of one pair carry different pixels");
            end
        end
    endtask

    task automatic check_vsync();
        logic prev_v, prev_hs, prev_vs;
        int   n;
        int   mid_falls = 0;
        prev_v = lvbl;
        @(negedge clk_vga);
        while (!(prev_v && !lvbl)) begin
            prev_v = lvbl;
            @(negedge clk_vga);
        end
        n = 0;
        while (vga_vb !== 1'b1 && n < 10) begin
            n++;
            @(negedge clk_vga);
        end
        assert (vga_vb === 1'b1) else begin
            errors++;
            $display("vga_vb did not rise after lvbl fell");
        end
        prev_hs = vga_hsync;
        prev_vs = vga_vsync;
        @(negedge clk_vga);
        while (!(prev_vs && !vga_vsync)) begin
            prev_hs = vga_hsync;
            prev_vs = vga_vsync;
            @(negedge clk_vga);
        end
        assert (prev_hs && !vga_hsync) else begin
            errors++;
            $display("vga_vsync fell away from an hsync falling edge");
        end
        while (!(!prev_vs && vga_vsync)) begin
            prev_hs = vga_hsync;
            prev_vs = vga_vsync;
            @(negedge clk_vga);
            if (prev_hs && !vga_hsync && !vga_vsync) mid_falls++;
        end
        assert (mid_falls == 1 && prev_hs && !vga_hsync) else begin
            errors++;
            $display("Fail t=%0t vga_vsync line count expected 2 got %0d",
                     $time, mid_falls + 1);
        end
        while (!lvbl) @(negedge clk_vga);
        n = 0;
        while (vga_vb !== 1'b0 && n < 10) begin
            n++;
            @(negedge clk_vga);
        end
        assert (vga_vb === 1'b0) else begin
            errors++;
            $display("vga_vb did not return low after lvbl rose");
        end
    endtask

    initial begin
        rst       = 1'b1;
        cen6      = 1'b0;
        lhbl      = 1'b0;
        lvbl      = 1'b1;
        en_mixing = 1'b0;
        {red, green, blue} = 12'd0;
        @(negedge clk_vga);
        check_reset_state("during reset");
        repeat (4) @(posedge clk_vga);
        rst    <= 1'b0;
        gen_on <= 1'b1;
        repeat (2) @(negedge clk_vga);          // one active edge past release
        check_reset_state("after reset");
        check_line_pairing();
        check_pair(1'b0);
        check_pair(1'b1);
        check_vsync();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
